/* Bender.yml */
package:
  name: rtc_xbar

sources:
  - rtl/rtc_xbar_pkg.sv
  - rtl/axi_rd_if.sv
  - rtl/axi_wr_if.sv
  - rtl/axi_xbar.sv
  - rtl/rtc_timer.sv
  - rtl/burst_ram.sv
  - rtl/rtc_xbar_top.sv
  - target: test
    files:
      - tests/tb_rtc_xbar.sv

/* rtc_xbar.f */
rtl/rtc_xbar_pkg.sv
rtl/axi_rd_if.sv
rtl/axi_wr_if.sv
rtl/axi_xbar.sv
rtl/rtc_timer.sv
rtl/burst_ram.sv
rtl/rtc_xbar_top.sv
tests/tb_rtc_xbar.sv

/* rtl/axi_rd_if.sv */
`timescale 1ns/1ps

interface axi_rd_if;

	// read address channel
	logic [rtc_xbar_pkg::ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;

	// read data channel
	logic [rtc_xbar_pkg::DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic rlast;

	modport manager (
		output araddr, arvalid, arlen, arsize, arburst, rready,
		input arready, rdata, rresp, rvalid, rlast
	);

	modport subordinate (
		input araddr, arvalid, arlen, arsize, arburst, rready,
		output arready, rdata, rresp, rvalid, rlast
	);

endinterface

/* rtl/axi_wr_if.sv */
`timescale 1ns/1ps

interface axi_wr_if;

	// single-beat write, no length field
	logic [rtc_xbar_pkg::ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [rtc_xbar_pkg::DATA_W-1:0] wdata;
	logic [rtc_xbar_pkg::DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	modport manager (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input awready, wready, bresp, bvalid
	);

	modport subordinate (
		input awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output awready, wready, bresp, bvalid
	);

endinterface

/* rtl/axi_xbar.sv */
`timescale 1ns/1ps

module axi_xbar #(
	parameter int RAM_WORDS = 1024
) (
	input logic clk,
	input logic rst,
	input logic [rtc_xbar_pkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	input logic [7:0] arlen,
	input logic [2:0] arsize,
	input logic [1:0] arburst,
	output logic [rtc_xbar_pkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic rlast,
	input logic [rtc_xbar_pkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [rtc_xbar_pkg::DATA_W-1:0] wdata,
	input logic [rtc_xbar_pkg::DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	axi_rd_if.manager ram_rd,
	axi_rd_if.manager rtc_rd,
	axi_wr_if.manager ram_wr
);

	localparam int RAM_BYTES = RAM_WORDS * (rtc_xbar_pkg::DATA_W / 8);
	localparam logic [rtc_xbar_pkg::ADDR_W-1:0] RAM_END = rtc_xbar_pkg::RAM_BASE + RAM_BYTES;
	localparam logic [rtc_xbar_pkg::ADDR_W-1:0] RTC_END =
		rtc_xbar_pkg::RTC_BASE + rtc_xbar_pkg::RTC_SIZE;

	// on the write side RT_RTC means a rejected write
	typedef enum logic [1:0] {RT_IDLE, RT_RAM, RT_RTC, RT_ERR} route_t;

	route_t rd_route;
	route_t wr_route;
	logic rd_ar_done;
	logic [7:0] err_len;
	logic [7:0] err_cnt;
	logic wr_aw_done;
	logic wr_w_done;

	function automatic route_t decode(input logic [rtc_xbar_pkg::ADDR_W-1:0] addr);
		if (addr >= rtc_xbar_pkg::RAM_BASE && addr < RAM_END)
			return RT_RAM;
		if (addr >= rtc_xbar_pkg::RTC_BASE && addr < RTC_END)
			return RT_RTC;
		return RT_ERR;
	endfunction

	// read route held from address until the rlast beat is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_route <= RT_IDLE;
			rd_ar_done <= 1'b0;
			err_cnt <= '0;
		end else if (rd_route == RT_IDLE) begin
			if (arvalid)
				rd_route <= decode(araddr);
			rd_ar_done <= 1'b0;
			err_cnt <= '0;
		end else begin
			if (arvalid && arready)
				rd_ar_done <= 1'b1;
			if (rvalid && rready) begin
				if (rlast) begin
					rd_route <= RT_IDLE;
					rd_ar_done <= 1'b0;
				end else if (rd_route == RT_ERR) begin
					err_cnt <= err_cnt + 8'd1;
				end
			end
		end
	end

	// burst length of an unmapped read
	always_ff @(posedge clk) begin
		if (rd_route == RT_ERR && arvalid && arready)
			err_len <= arlen;
	end

	always_comb begin
		ram_rd.araddr = araddr;
		ram_rd.arlen = arlen;
		ram_rd.arsize = arsize;
		ram_rd.arburst = arburst;
		ram_rd.arvalid = 1'b0;
		ram_rd.rready = 1'b0;
		// counter link is always one beat
		rtc_rd.araddr = araddr;
		rtc_rd.arlen = '0;
		rtc_rd.arsize = arsize;
		rtc_rd.arburst = rtc_xbar_pkg::BURST_INCR;
		rtc_rd.arvalid = 1'b0;
		rtc_rd.rready = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rresp = rtc_xbar_pkg::RESP_OKAY;
		rvalid = 1'b0;
		rlast = 1'b0;
		case (rd_route)
			RT_RAM: begin
				ram_rd.arvalid = arvalid && !rd_ar_done;
				arready = ram_rd.arready && !rd_ar_done;
				rdata = ram_rd.rdata;
				rresp = ram_rd.rresp;
				rvalid = ram_rd.rvalid;
				rlast = ram_rd.rlast;
				ram_rd.rready = rready;
			end
			RT_RTC: begin
				rtc_rd.arvalid = arvalid && !rd_ar_done;
				arready = rtc_rd.arready && !rd_ar_done;
				rdata = rtc_rd.rdata;
				rresp = rtc_rd.rresp;
				rvalid = rtc_rd.rvalid;
				rlast = rtc_rd.rlast;
				rtc_rd.rready = rready;
			end
			RT_ERR: begin
				arready = !rd_ar_done;
				rvalid = rd_ar_done;
				rresp = rtc_xbar_pkg::RESP_DECERR;
				rlast = err_cnt == err_len;
			end
			default: begin
			end
		endcase
	end

	// write route, aw and w each taken once
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_route <= RT_IDLE;
			wr_aw_done <= 1'b0;
			wr_w_done <= 1'b0;
		end else if (wr_route == RT_IDLE) begin
			if (awvalid)
				wr_route <= decode(awaddr);
			wr_aw_done <= 1'b0;
			wr_w_done <= 1'b0;
		end else begin
			if (awvalid && awready)
				wr_aw_done <= 1'b1;
			if (wvalid && wready)
				wr_w_done <= 1'b1;
			if (bvalid && bready) begin
				wr_route <= RT_IDLE;
				wr_aw_done <= 1'b0;
				wr_w_done <= 1'b0;
			end
		end
	end

	always_comb begin
		ram_wr.awaddr = awaddr;
		ram_wr.wdata = wdata;
		ram_wr.wstrb = wstrb;
		ram_wr.awvalid = 1'b0;
		ram_wr.wvalid = 1'b0;
		ram_wr.bready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bresp = rtc_xbar_pkg::RESP_OKAY;
		bvalid = 1'b0;
		case (wr_route)
			RT_RAM: begin
				ram_wr.awvalid = awvalid && !wr_aw_done;
				awready = ram_wr.awready && !wr_aw_done;
				ram_wr.wvalid = wvalid && !wr_w_done;
				wready = ram_wr.wready && !wr_w_done;
				bresp = ram_wr.bresp;
				bvalid = ram_wr.bvalid;
				ram_wr.bready = bready;
			end
			RT_RTC, RT_ERR: begin
				awready = !wr_aw_done;
				wready = !wr_w_done;
				// answer the cycle after both channels are absorbed
				bvalid = wr_aw_done && wr_w_done;
				bresp = (wr_route == RT_RTC) ? rtc_xbar_pkg::RESP_SLVERR
					: rtc_xbar_pkg::RESP_DECERR;
			end
			default: begin
			end
		endcase
	end

	// a ram burst keeps its route until its last beat is taken
	a_rd_route_stable: assert property (@(posedge clk) disable iff (rst)
		(ram_rd.rvalid && !(ram_rd.rready && ram_rd.rlast)) |=> rd_route == RT_RAM)
		else $error("read route changed inside an open burst");

	a_rvalid_selected: assert property (@(posedge clk) disable iff (rst)
		(ram_rd.rvalid |-> rd_route == RT_RAM) and (rtc_rd.rvalid |-> rd_route == RT_RTC))
		else $error("read data from a target that is not routed");

endmodule

/* rtl/burst_ram.sv */
`timescale 1ns/1ps

module burst_ram #(
	parameter int RAM_WORDS = 1024
) (
	input logic clk,
	input logic rst,
	axi_rd_if.subordinate rd,
	axi_wr_if.subordinate wr
);

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int LEN_W = $clog2(rtc_xbar_pkg::MAX_BURST_LEN);
	localparam int BYTES = rtc_xbar_pkg::DATA_W / 8;

	logic [rtc_xbar_pkg::DATA_W-1:0] mem [RAM_WORDS];

	logic [IDX_W-1:0] rd_idx;
	logic [LEN_W-1:0] rd_left;
	logic [IDX_W-1:0] ar_idx;

	logic aw_held;
	logic w_held;
	logic [IDX_W-1:0] aw_idx_q;
	logic [rtc_xbar_pkg::DATA_W-1:0] wdata_q;
	logic [BYTES-1:0] wstrb_q;
	logic aw_got;
	logic w_got;
	logic wr_fire;
	logic [IDX_W-1:0] wr_idx;
	logic [rtc_xbar_pkg::DATA_W-1:0] wr_data;
	logic [BYTES-1:0] wr_strb;

	assign ar_idx = rd.araddr[IDX_W+1:2];

	// busy while a burst is streaming
	assign rd.arready = !rd.rvalid;
	assign rd.rresp = rtc_xbar_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd.rvalid <= 1'b0;
		end else if (rd.arvalid && rd.arready) begin
			rd.rvalid <= 1'b1;
		end else if (rd.rready && rd.rlast) begin
			rd.rvalid <= 1'b0;
		end
	end

	// beat data, address stepping
	always_ff @(posedge clk) begin
		if (rd.arvalid && rd.arready) begin
			rd.rdata <= mem[ar_idx];
			rd.rlast <= rd.arlen == 8'd0;
			rd_idx <= ar_idx + 1'b1;
			rd_left <= rd.arlen[LEN_W-1:0];
		end else if (rd.rvalid && rd.rready && !rd.rlast) begin
			rd.rdata <= mem[rd_idx];
			rd.rlast <= rd_left == LEN_W'(1);
			rd_idx <= rd_idx + 1'b1;
			rd_left <= rd_left - 1'b1;
		end
	end

	// aw and w in either order, completed together
	assign wr.awready = !aw_held && !wr.bvalid;
	assign wr.wready = !w_held && !wr.bvalid;
	assign wr.bresp = rtc_xbar_pkg::RESP_OKAY;
	assign aw_got = aw_held || (wr.awvalid && wr.awready);
	assign w_got = w_held || (wr.wvalid && wr.wready);
	assign wr_fire = aw_got && w_got && !wr.bvalid;
	assign wr_idx = aw_held ? aw_idx_q : wr.awaddr[IDX_W+1:2];
	assign wr_data = w_held ? wdata_q : wr.wdata;
	assign wr_strb = w_held ? wstrb_q : wr.wstrb;

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			wr.bvalid <= 1'b0;
		end else if (wr_fire) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			wr.bvalid <= 1'b1;
		end else begin
			aw_held <= aw_got;
			w_held <= w_got;
			if (wr.bready)
				wr.bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.awvalid && wr.awready)
			aw_idx_q <= wr.awaddr[IDX_W+1:2];
		if (wr.wvalid && wr.wready) begin
			wdata_q <= wr.wdata;
			wstrb_q <= wr.wstrb;
		end
		if (wr_fire) begin
			for (int b = 0; b < BYTES; b++) begin
				if (wr_strb[b])
					mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	a_incr_only: assert property (@(posedge clk) disable iff (rst)
		rd.arvalid |-> (rd.arburst == rtc_xbar_pkg::BURST_INCR
			&& rd.arlen < rtc_xbar_pkg::MAX_BURST_LEN))
		else $error("unsupported burst type or length at ram");

endmodule

/* rtl/rtc_timer.sv */
`timescale 1ns/1ps

module rtc_timer #(
	parameter int TICKS_PER_US = 25
) (
	input logic clk,
	input logic rst,
	axi_rd_if.subordinate rd
);

	localparam int PRE_W = (TICKS_PER_US > 1) ? $clog2(TICKS_PER_US) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_US - 1);

	logic [PRE_W-1:0] prescale;
	logic [63:0] usec;
	logic [31:0] hi_snap;

	// microsecond tick
	always_ff @(posedge clk) begin
		if (rst) begin
			prescale <= '0;
			usec <= '0;
		end else if (prescale == PRE_LAST) begin
			prescale <= '0;
			usec <= usec + 64'd1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// one transfer at a time
	assign rd.arready = !rd.rvalid;
	assign rd.rresp = rtc_xbar_pkg::RESP_OKAY;
	assign rd.rlast = 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd.rvalid <= 1'b0;
		end else if (rd.arvalid && rd.arready) begin
			rd.rvalid <= 1'b1;
		end else if (rd.rready) begin
			rd.rvalid <= 1'b0;
		end
	end

	// low word read freezes the high word for the next read
	always_ff @(posedge clk) begin
		if (rd.arvalid && rd.arready) begin
			if (!rd.araddr[2]) begin
				rd.rdata <= usec[31:0];
				hi_snap <= usec[63:32];
			end else begin
				rd.rdata <= hi_snap;
			end
		end
	end

endmodule

/* rtl/rtc_xbar_pkg.sv */
package rtc_xbar_pkg;

	// bus widths
	parameter int ADDR_W = 32;
	parameter int DATA_W = 32;

	// axi response codes
	parameter logic [1:0] RESP_OKAY   = 2'b00;
	parameter logic [1:0] RESP_SLVERR = 2'b10;
	parameter logic [1:0] RESP_DECERR = 2'b11;

	// only incrementing bursts are served
	parameter logic [1:0] BURST_INCR = 2'b01;

	// system ram window
	parameter logic [ADDR_W-1:0] RAM_BASE = 32'h8000_0000;
	parameter int RAM_SIZE = 4096;

	// real-time counter, low word then high word
	parameter logic [ADDR_W-1:0] RTC_BASE = 32'hA000_0048;
	parameter int RTC_SIZE = 8;

	// arlen + 1 upper bound
	parameter int MAX_BURST_LEN = 16;

endpackage

/* rtl/rtc_xbar_top.sv */
`timescale 1ns/1ps

module rtc_xbar_top #(
	parameter int RAM_WORDS = rtc_xbar_pkg::RAM_SIZE / (rtc_xbar_pkg::DATA_W / 8),
	parameter int TICKS_PER_US = 25
) (
	input logic clk,
	input logic rst,
	input logic [rtc_xbar_pkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	input logic [7:0] arlen,
	input logic [2:0] arsize,
	input logic [1:0] arburst,
	output logic [rtc_xbar_pkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic rlast,
	input logic [rtc_xbar_pkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [rtc_xbar_pkg::DATA_W-1:0] wdata,
	input logic [rtc_xbar_pkg::DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready
);

	axi_rd_if ram_rd ();
	axi_rd_if rtc_rd ();
	axi_wr_if ram_wr ();

	axi_xbar #(
		.RAM_WORDS(RAM_WORDS)
	) u_axi_xbar (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.rlast(rlast),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.ram_rd(ram_rd.manager),
		.rtc_rd(rtc_rd.manager),
		.ram_wr(ram_wr.manager)
	);

	// system side ram
	burst_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_burst_ram (
		.clk(clk),
		.rst(rst),
		.rd(ram_rd.subordinate),
		.wr(ram_wr.subordinate)
	);

	// read-only counter, writes stop at the crossbar
	rtc_timer #(
		.TICKS_PER_US(TICKS_PER_US)
	) u_rtc_timer (
		.clk(clk),
		.rst(rst),
		.rd(rtc_rd.subordinate)
	);

endmodule

/* tests/tb_rtc_xbar.sv */
`timescale 1ns/1ps

module tb_rtc_xbar;

	localparam int TIMEOUT = 200;
	localparam int WIN_WORDS = 64;
	localparam logic [31:0] UNMAPPED = 32'h4000_0000;
	localparam logic [1:0] OKAY = rtc_xbar_pkg::RESP_OKAY;

	logic clk;
	logic rst;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic rlast;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	// expected contents of the first WIN_WORDS words of the ram
	logic [31:0] model [WIN_WORDS];
	logic [31:0] got_data [32];
	logic [1:0] got_resp [32];
	int got_n;
	int errors;
	int checks;
	bit timed_out;

	rtc_xbar_top u_rtc_xbar_top (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready), .arlen(arlen),
		.arsize(arsize), .arburst(arburst), .rdata(rdata), .rresp(rresp),
		.rvalid(rvalid), .rready(rready), .rlast(rlast),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
		.wstrb(wstrb), .wvalid(wvalid), .wready(wready), .bresp(bresp),
		.bvalid(bvalid), .bready(bready)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] word_addr(input int idx);
		return rtc_xbar_pkg::RAM_BASE + 32'(idx) * 32'd4;
	endfunction

	// byte lanes without a strobe keep their old value
	function automatic void model_write(input int idx, input logic [31:0] data,
			input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				model[idx][8*b +: 8] = data[8*b +: 8];
		end
	endfunction

	task automatic note_timeout(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		bit aw_open;
		bit w_open;
		bit aw_fire;
		bit w_fire;
		bit resp_seen;
		int cyc;
		resp = 2'bxx;
		if (timed_out)
			return;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= 1'b1;
		aw_open = 1'b1;
		w_open = 1'b1;
		cyc = 0;
		while ((aw_open || w_open) && cyc < TIMEOUT) begin
			@(negedge clk);
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			@(posedge clk);
			if (aw_fire) begin
				awvalid <= 1'b0;
				aw_open = 1'b0;
			end
			if (w_fire) begin
				wvalid <= 1'b0;
				w_open = 1'b0;
			end
			cyc++;
		end
		if (aw_open || w_open) begin
			note_timeout("the write address and data handshakes");
			return;
		end
		resp_seen = 1'b0;
		cyc = 0;
		while (!resp_seen && cyc < TIMEOUT) begin
			bready <= ($urandom % 4) != 0;
			@(negedge clk);
			if (bvalid && bready) begin
				resp = bresp;
				resp_seen = 1'b1;
			end
			@(posedge clk);
			cyc++;
		end
		bready <= 1'b0;
		if (!resp_seen)
			note_timeout("the write response");
	endtask

	// collects beats up to rlast into got_data and got_resp
	task automatic axi_read(input logic [31:0] addr, input logic [7:0] len);
		bit ar_open;
		bit done;
		int cyc;
		got_n = 0;
		if (timed_out)
			return;
		@(posedge clk);
		araddr <= addr;
		arlen <= len;
		arsize <= 3'd2;
		arburst <= rtc_xbar_pkg::BURST_INCR;
		arvalid <= 1'b1;
		ar_open = 1'b1;
		cyc = 0;
		while (ar_open && cyc < TIMEOUT) begin
			@(negedge clk);
			if (arvalid && arready)
				ar_open = 1'b0;
			@(posedge clk);
			cyc++;
		end
		arvalid <= 1'b0;
		if (ar_open) begin
			note_timeout("the read address handshake");
			return;
		end
		done = 1'b0;
		cyc = 0;
		while (!done && cyc < TIMEOUT) begin
			rready <= ($urandom % 3) != 0;
			@(negedge clk);
			if (rvalid && rready) begin
				if (got_n < 32) begin
					got_data[got_n] = rdata;
					got_resp[got_n] = rresp;
				end
				got_n++;
				done = rlast;
			end
			@(posedge clk);
			cyc++;
		end
		rready <= 1'b0;
		if (!done)
			note_timeout("the last read beat");
	endtask

	// mode 0 data from the model, 1 zero data, 2 data not checked
	task automatic check_beats(input string what, input int n_exp, input int mode,
			input int idx, input logic [1:0] exp_resp);
		logic [31:0] exp_data;
		if (timed_out)
			return;
		checks++;
		if (got_n != n_exp) begin
			$display("%s returned %0d beats instead of %0d", what, got_n, n_exp);
			errors++;
			return;
		end
		for (int k = 0; k < n_exp; k++) begin
			exp_data = (mode == 0) ? model[idx + k] : 32'h0;
			checks++;
			if (got_resp[k] !== exp_resp) begin
				$display("Fail rresp %s beat %0d: got %h expected %h",
					what, k, got_resp[k], exp_resp);
				errors++;
			end
			if (mode != 2 && got_data[k] !== exp_data) begin
				$display("Fail rdata %s beat %0d: got %h expected %h",
					what, k, got_data[k], exp_data);
				errors++;
			end
		end
	endtask

	task automatic check_bresp(input string what, input logic [1:0] got,
			input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail bresp %s: got %h expected %h", what, got, exp);
			errors++;
		end
	endtask

	// low word first, the high word comes from the snapshot
	task automatic read_rtc(output logic [63:0] value);
		logic [31:0] lo;
		axi_read(rtc_xbar_pkg::RTC_BASE, 8'd0);
		check_beats("rtc low word", 1, 2, 0, OKAY);
		lo = got_data[0];
		axi_read(rtc_xbar_pkg::RTC_BASE + 32'd4, 8'd0);
		check_beats("rtc high word", 1, 2, 0, OKAY);
		value = {got_data[0], lo};
	endtask

	task automatic end_test(input string name, input int start_err);
		$display("test %s finished with %0d errors", name, errors - start_err);
	endtask

	task automatic run_ram_writes();
		logic [1:0] resp;
		logic [31:0] data;
		logic [3:0] strb;
		int idx;
		int start_err;
		start_err = errors;
		// ram content is unknown after reset, zero the window first
		for (int i = 0; i < WIN_WORDS; i++) begin
			axi_write(word_addr(i), 32'h0, 4'hf, resp);
			check_bresp("ram clear", resp, OKAY);
		end
		for (int n = 0; n < 48; n++) begin
			idx = $urandom % WIN_WORDS;
			data = $urandom;
			strb = 4'($urandom);
			axi_write(word_addr(idx), data, strb, resp);
			model_write(idx, data, strb);
			check_bresp("ram write", resp, OKAY);
		end
		for (int n = 0; n < 48; n++) begin
			idx = $urandom % WIN_WORDS;
			axi_read(word_addr(idx), 8'd0);
			check_beats("ram single read", 1, 0, idx, OKAY);
		end
		end_test("ram_writes", start_err);
	endtask

	task automatic run_ram_bursts();
		int len;
		int idx;
		int start_err;
		start_err = errors;
		for (int n = 0; n < 30; n++) begin
			len = $urandom % rtc_xbar_pkg::MAX_BURST_LEN;
			idx = $urandom % (WIN_WORDS - len);
			axi_read(word_addr(idx), 8'(len));
			check_beats("ram burst", len + 1, 0, idx, OKAY);
		end
		end_test("ram_bursts", start_err);
	endtask

	task automatic run_rtc_write_reject();
		logic [1:0] resp;
		logic [31:0] addr;
		int idx;
		int start_err;
		start_err = errors;
		for (int n = 0; n < 6; n++) begin
			addr = rtc_xbar_pkg::RTC_BASE + 32'd4 * ($urandom % 2);
			axi_write(addr, $urandom, 4'hf, resp);
			check_bresp("rtc write", resp, rtc_xbar_pkg::RESP_SLVERR);
			// a leaked write would land on the ram word with the same low address bits
			idx = int'((addr % rtc_xbar_pkg::RAM_SIZE) / 4);
			axi_read(word_addr(idx), 8'd0);
			check_beats("ram reread", 1, 0, idx, OKAY);
		end
		end_test("rtc_write_reject", start_err);
	endtask

	task automatic run_unmapped();
		logic [1:0] resp;
		logic [31:0] addr;
		int len;
		int start_err;
		start_err = errors;
		for (int n = 0; n < 8; n++) begin
			addr = UNMAPPED | ($urandom & 32'h0000_fffc);
			len = $urandom % rtc_xbar_pkg::MAX_BURST_LEN;
			axi_read(addr, 8'(len));
			check_beats("unmapped burst", len + 1, 1, 0, rtc_xbar_pkg::RESP_DECERR);
			@(negedge clk);
			if (rvalid) begin
				$display("rvalid stayed high after the last unmapped beat");
				errors++;
			end
			axi_write(addr, $urandom, 4'hf, resp);
			check_bresp("unmapped write", resp, rtc_xbar_pkg::RESP_DECERR);
		end
		end_test("unmapped", start_err);
	endtask

	task automatic run_rtc_counter();
		logic [63:0] prev;
		logic [63:0] now;
		int gap;
		int start_err;
		start_err = errors;
		read_rtc(prev);
		for (int n = 0; n < 8; n++) begin
			read_rtc(now);
			checks++;
			if (now < prev) begin
				$display("Fail rtc count: got %h expected at least %h", now, prev);
				errors++;
			end
			prev = now;
		end
		for (int n = 0; n < 4; n++) begin
			gap = 100 + $urandom % 500;
			read_rtc(prev);
			repeat (gap) @(posedge clk);
			read_rtc(now);
			checks++;
			if (now - prev < 64'(gap / 25 - 1)) begin
				$display("Fail rtc delta: got %h expected at least %h",
					now - prev, gap / 25 - 1);
				errors++;
			end
		end
		end_test("rtc_counter", start_err);
	endtask

	// route must be released on rlast before the next target is chosen
	task automatic run_route_switch();
		logic [63:0] value;
		int len;
		int idx;
		int start_err;
		start_err = errors;
		for (int n = 0; n < 6; n++) begin
			len = $urandom % rtc_xbar_pkg::MAX_BURST_LEN;
			idx = $urandom % (WIN_WORDS - len);
			read_rtc(value);
			axi_read(word_addr(idx), 8'(len));
			check_beats("ram burst after rtc", len + 1, 0, idx, OKAY);
			read_rtc(value);
		end
		end_test("route_switch", start_err);
	endtask

	initial begin
		int unsigned seed;
		seed = 32'h82e79510;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		arlen = '0;
		arsize = 3'd2;
		arburst = rtc_xbar_pkg::BURST_INCR;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		for (int i = 0; i < WIN_WORDS; i++)
			model[i] = 32'h0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		run_ram_writes();
		run_ram_bursts();
		run_rtc_write_reject();
		run_unmapped();
		run_rtc_counter();
		run_route_switch();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
